//--- Makefile
VERILATOR ?= verilator
TOP       := tb_ft2232_host_model
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulation binary carries pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- common/ft2232_pkg.sv
// ======================================================================
// FT2232 host model shared widths, command encodings, header and
// status structs and the default stream configuration
// ======================================================================

package ft2232_pkg;

    // Bus and header field widths
    localparam int FT_DATA_W = 8;
    localparam int FT_LEN_W  = 6;
    localparam int FT_CMD_W  = 2;

    typedef logic [FT_DATA_W-1:0] ft_byte_t;
    typedef logic [FT_LEN_W-1:0]  ft_len_t;

    // Commands sent by the host toward the FPGA
    typedef enum logic [FT_CMD_W-1:0] {
        CMD_SETUP_OUTPUT  = 2'b00,
        CMD_STREAM_OUTPUT = 2'b01,
        CMD_STOP          = 2'b11
    } ft_host_cmd_e;

    // Commands written by the FPGA, 2'b10 is not defined
    typedef enum logic [FT_CMD_W-1:0] {
        CMD_STREAM_CFG   = 2'b00,
        CMD_STREAM_INPUT = 2'b01,
        CMD_STOPPED      = 2'b11
    } ft_dev_cmd_e;

    // Header byte, command in the top two bits
    typedef struct packed {
        logic [FT_CMD_W-1:0] cmd;
        ft_len_t             len;
    } ft_header_t;

    // Stream configuration payload byte
    typedef struct packed {
        logic       channels;
        logic [1:0] io_type;
        logic [2:0] sample_rate;
        logic [1:0] bit_depth;
    } ft_stream_cfg_t;

    // Configuration field codes
    localparam logic       CFG_CHANNELS_STEREO = 1'b1;
    localparam logic [1:0] CFG_IO_TYPE_BNC     = 2'b01;
    localparam logic [2:0] CFG_RATE_48000_HZ   = 3'b011;
    localparam logic [1:0] CFG_BIT_DEPTH_24    = 2'b10;

    localparam ft_stream_cfg_t FT_STREAM_CFG_DEFAULT = '{
        channels:    CFG_CHANNELS_STEREO,
        io_type:     CFG_IO_TYPE_BNC,
        sample_rate: CFG_RATE_48000_HZ,
        bit_depth:   CFG_BIT_DEPTH_24
    };

    typedef enum logic [1:0] {
        HALT_NONE        = 2'b00,
        HALT_MISMATCH    = 2'b01,
        HALT_UNKNOWN_CMD = 2'b10
    } ft_halt_e;

    // Receive side status seen by the testbench
    typedef struct packed {
        ft_halt_e halt;
        logic     stopped;
        ft_byte_t stop_code;
        ft_byte_t expected;
    } ft_host_status_t;

endpackage

//--- hdl/ft2232_flow_ctrl.sv
// ======================================================================
// FT2232 clock gating and RXF#/TXE# status levels with the
// one-time empty FIFO stall counter
// ======================================================================

`timescale 1ns/1ps

module ft2232_flow_ctrl #(
    parameter int OUT_EMPTY_CYCLES = 0
) (
    input  logic osc_clk_i,
    input  logic ft2232_reset_n_i,
    input  logic stall_req_i,
    input  logic out_done_i,
    input  logic stop_seen_i,
    input  logic halted_i,
    output logic fifo_clk_o,
    output logic fifo_rxf_n_o,
    output logic fifo_txe_n_o
);

    // Counter must hold OUT_EMPTY_CYCLES, at least one bit wide
    localparam int CNT_W = (OUT_EMPTY_CYCLES > 1) ? $clog2(OUT_EMPTY_CYCLES + 1) : 1;

    logic [CNT_W-1:0] stall_cnt;
    logic             rxf_latched;
    logic             txe_latched;

    // No clock edges while the device is held in reset
    assign fifo_clk_o = ft2232_reset_n_i & osc_clk_i;

    // ==================================================================
    // Status levels
    // ==================================================================

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            stall_cnt   <= '0;
            rxf_latched <= 1'b0;
            txe_latched <= 1'b0;
        end else begin
            // Empty FIFO window, a zero count never opens it
            if (stall_req_i) begin
                stall_cnt <= CNT_W'(OUT_EMPTY_CYCLES);
            end else if (stall_cnt != '0) begin
                stall_cnt <= stall_cnt - 1'b1;
            end

            // Nothing more to send once stopped, done or halted
            if (out_done_i || stop_seen_i || halted_i) begin
                rxf_latched <= 1'b1;
            end

            if (halted_i) begin
                txe_latched <= 1'b1;
            end
        end
    end

    assign fifo_rxf_n_o = rxf_latched | (stall_cnt != '0);
    assign fifo_txe_n_o = txe_latched;

endmodule

//--- hdl/ft2232_host_model.sv
// ======================================================================
// FT2232 synchronous FIFO host model top level
// ======================================================================

`timescale 1ns/1ps

module ft2232_host_model #(
    parameter int PACKET_COUNT     = 1,
    parameter int PACKET_PAYLOAD   = 60,
    parameter int OUT_EMPTY_CYCLES = 0
) (
    input  logic                        osc_clk_i,
    input  logic                        ft2232_reset_n_i,
    input  logic                        fifo_oe_n_i,
    input  logic                        fifo_rd_n_i,
    input  logic                        fifo_wr_n_i,
    input  ft2232_pkg::ft_byte_t        fifo_data_i,
    output logic                        fifo_clk_o,
    output logic                        fifo_rxf_n_o,
    output logic                        fifo_txe_n_o,
    output ft2232_pkg::ft_byte_t        fifo_data_o,
    output ft2232_pkg::ft_host_status_t status_o
);

    // Stage handshake levels and pulses
    logic stall_req;
    logic out_done;
    logic stop_seen;
    logic halted;

    ft2232_flow_ctrl #(
        .OUT_EMPTY_CYCLES(OUT_EMPTY_CYCLES)
    ) ft2232_flow_ctrl_inst (
        .osc_clk_i       (osc_clk_i),
        .ft2232_reset_n_i(ft2232_reset_n_i),
        .stall_req_i     (stall_req),
        .out_done_i      (out_done),
        .stop_seen_i     (stop_seen),
        .halted_i        (halted),
        .fifo_clk_o      (fifo_clk_o),
        .fifo_rxf_n_o    (fifo_rxf_n_o),
        .fifo_txe_n_o    (fifo_txe_n_o)
    );

    // Send path
    ft2232_out_sequencer #(
        .PACKET_COUNT  (PACKET_COUNT),
        .PACKET_PAYLOAD(PACKET_PAYLOAD)
    ) ft2232_out_sequencer_inst (
        .fifo_clk_o      (fifo_clk_o),
        .ft2232_reset_n_i(ft2232_reset_n_i),
        .fifo_rxf_n_i    (fifo_rxf_n_o),
        .fifo_oe_n_i     (fifo_oe_n_i),
        .fifo_rd_n_i     (fifo_rd_n_i),
        .fifo_data_o     (fifo_data_o),
        .stall_req_o     (stall_req),
        .out_done_o      (out_done)
    );

    // Receive path
    ft2232_in_parser ft2232_in_parser_inst (
        .fifo_clk_o      (fifo_clk_o),
        .ft2232_reset_n_i(ft2232_reset_n_i),
        .fifo_txe_n_i    (fifo_txe_n_o),
        .fifo_oe_n_i     (fifo_oe_n_i),
        .fifo_wr_n_i     (fifo_wr_n_i),
        .fifo_data_i     (fifo_data_i),
        .status_o        (status_o),
        .stop_seen_o     (stop_seen),
        .halted_o        (halted)
    );

endmodule

//--- in_path/ft2232_in_parser.sv
// ======================================================================
// Receive side parser: command decode, input data check and
// stop code capture
// ======================================================================

`timescale 1ns/1ps

module ft2232_in_parser (
    input  logic                        fifo_clk_o,
    input  logic                        ft2232_reset_n_i,
    input  logic                        fifo_txe_n_i,
    input  logic                        fifo_oe_n_i,
    input  logic                        fifo_wr_n_i,
    input  ft2232_pkg::ft_byte_t        fifo_data_i,
    output ft2232_pkg::ft_host_status_t status_o,
    output logic                        stop_seen_o,
    output logic                        halted_o
);

    typedef enum logic [1:0] {
        IN_CMD,
        IN_PAYLOAD,
        IN_HALTED
    } in_state_e;

    in_state_e               state;
    ft2232_pkg::ft_dev_cmd_e last_cmd;
    ft2232_pkg::ft_len_t     remaining;
    logic                    first_byte;
    ft2232_pkg::ft_header_t  hdr;
    logic                    write_xfer;

    // Bus is driven by the FPGA while OE# is high
    assign write_xfer = !fifo_txe_n_i && fifo_oe_n_i && !fifo_wr_n_i;
    assign hdr        = ft2232_pkg::ft_header_t'(fifo_data_i);
    assign halted_o   = (state == IN_HALTED);

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state      <= IN_CMD;
            last_cmd   <= ft2232_pkg::CMD_STREAM_CFG;
            remaining  <= '0;
            first_byte <= 1'b0;
            stop_seen_o <= 1'b0;
            status_o   <= '{halt: ft2232_pkg::HALT_NONE, stopped: 1'b0,
                            stop_code: '0, expected: '0};
        end else begin
            stop_seen_o <= 1'b0;
            if (write_xfer) begin
                case (state)
                    // ==================================================
                    // Header byte
                    // ==================================================
                    IN_CMD: begin
                        last_cmd   <= ft2232_pkg::ft_dev_cmd_e'(hdr.cmd);
                        remaining  <= hdr.len;
                        first_byte <= 1'b1;
                        case (ft2232_pkg::ft_dev_cmd_e'(hdr.cmd))
                            // Config always carries one byte
                            ft2232_pkg::CMD_STREAM_CFG: state <= IN_PAYLOAD;
                            ft2232_pkg::CMD_STREAM_INPUT: begin
                                if (hdr.len != '0) begin
                                    state <= IN_PAYLOAD;
                                end
                            end
                            ft2232_pkg::CMD_STOPPED: begin
                                stop_seen_o      <= 1'b1;
                                status_o.stopped <= 1'b1;
                                if (hdr.len != '0) begin
                                    state <= IN_PAYLOAD;
                                end
                            end
                            default: begin
                                status_o.halt <= ft2232_pkg::HALT_UNKNOWN_CMD;
                                state         <= IN_HALTED;
                            end
                        endcase
                    end
                    // ==================================================
                    // Payload bytes
                    // ==================================================
                    IN_PAYLOAD: begin
                        case (last_cmd)
                            ft2232_pkg::CMD_STREAM_CFG: state <= IN_CMD;
                            ft2232_pkg::CMD_STREAM_INPUT: begin
                                if (fifo_data_i == status_o.expected) begin
                                    status_o.expected <= status_o.expected + 8'd1;
                                    remaining <= remaining - 6'd1;
                                    if (remaining == 6'd1) begin
                                        state <= IN_CMD;
                                    end
                                end else begin
                                    status_o.halt <= ft2232_pkg::HALT_MISMATCH;
                                    state         <= IN_HALTED;
                                end
                            end
                            default: begin
                                // Stopped, first byte is the error code
                                if (first_byte) begin
                                    status_o.stop_code <= fifo_data_i;
                                    first_byte         <= 1'b0;
                                end
                                remaining <= remaining - 6'd1;
                                if (remaining == 6'd1) begin
                                    state <= IN_CMD;
                                end
                            end
                        endcase
                    end
                    default: state <= IN_HALTED;
                endcase
            end
        end
    end

endmodule

//--- out_path/ft2232_out_sequencer.sv
// ======================================================================
// Playback byte stream sequencer: setup, stream packets and stop
// ======================================================================

`timescale 1ns/1ps

module ft2232_out_sequencer #(
    parameter int PACKET_COUNT   = 1,
    parameter int PACKET_PAYLOAD = 60
) (
    input  logic                 fifo_clk_o,
    input  logic                 ft2232_reset_n_i,
    input  logic                 fifo_rxf_n_i,
    input  logic                 fifo_oe_n_i,
    input  logic                 fifo_rd_n_i,
    output ft2232_pkg::ft_byte_t fifo_data_o,
    output logic                 stall_req_o,
    output logic                 out_done_o
);

    localparam int PKT_W = $clog2(PACKET_COUNT + 1);
    localparam ft2232_pkg::ft_len_t PAYLOAD_LEN = ft2232_pkg::ft_len_t'(PACKET_PAYLOAD);
    // Remaining count at which the single stall is taken
    localparam ft2232_pkg::ft_len_t STALL_AT = ft2232_pkg::ft_len_t'(PACKET_PAYLOAD / 2);

    typedef enum logic [2:0] {
        OUT_START_CMD,
        OUT_START_CFG,
        OUT_DATA_CMD,
        OUT_DATA_PAYLOAD,
        OUT_STOP_CMD,
        OUT_IDLE
    } out_state_e;

    out_state_e           state;
    ft2232_pkg::ft_len_t  payload_cnt;
    logic [PKT_W-1:0]     packet_cnt;
    ft2232_pkg::ft_byte_t data_cnt;
    logic                 stall_taken;
    ft2232_pkg::ft_byte_t next_byte;
    logic                 read_xfer;
    logic                 load;

    function automatic ft2232_pkg::ft_byte_t make_header(ft2232_pkg::ft_host_cmd_e cmd,
                                                         ft2232_pkg::ft_len_t len);
        ft2232_pkg::ft_header_t hdr;
        hdr.cmd = cmd;
        hdr.len = len;
        return ft2232_pkg::ft_byte_t'(hdr);
    endfunction

    // Data moves on every edge with RXF#, OE# and RD# all low
    assign read_xfer   = !fifo_rxf_n_i && !fifo_oe_n_i && !fifo_rd_n_i;
    assign stall_req_o = read_xfer && (state == OUT_DATA_PAYLOAD) && !stall_taken &&
                         (payload_cnt == STALL_AT);
    assign load        = read_xfer && (state != OUT_IDLE) && !stall_req_o;
    assign out_done_o  = (state == OUT_IDLE);

    always_comb begin
        case (state)
            OUT_START_CMD:    next_byte = make_header(ft2232_pkg::CMD_SETUP_OUTPUT, 6'd1);
            OUT_START_CFG:    next_byte = ft2232_pkg::FT_STREAM_CFG_DEFAULT;
            OUT_DATA_CMD:     next_byte = make_header(ft2232_pkg::CMD_STREAM_OUTPUT, PAYLOAD_LEN);
            OUT_DATA_PAYLOAD: next_byte = data_cnt;
            OUT_STOP_CMD:     next_byte = make_header(ft2232_pkg::CMD_STOP, 6'd0);
            default:          next_byte = fifo_data_o;
        endcase
    end

    // Output byte register
    always_ff @(posedge fifo_clk_o) begin
        if (load) begin
            fifo_data_o <= next_byte;
        end
    end

    // ==================================================================
    // Stream state machine
    // ==================================================================

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state       <= OUT_START_CMD;
            payload_cnt <= '0;
            packet_cnt  <= '0;
            data_cnt    <= '0;
            stall_taken <= 1'b0;
        end else begin
            if (stall_req_o) begin
                stall_taken <= 1'b1;
            end
            if (load) begin
                case (state)
                    OUT_START_CMD: begin
                        packet_cnt <= PKT_W'(PACKET_COUNT);
                        data_cnt   <= '0;
                        state      <= OUT_START_CFG;
                    end
                    OUT_START_CFG: state <= OUT_DATA_CMD;
                    OUT_DATA_CMD: begin
                        payload_cnt <= PAYLOAD_LEN;
                        state       <= OUT_DATA_PAYLOAD;
                    end
                    OUT_DATA_PAYLOAD: begin
                        // Counting bytes carry on into the next packet
                        data_cnt    <= data_cnt + 8'd1;
                        payload_cnt <= payload_cnt - 6'd1;
                        if (payload_cnt == 6'd1) begin
                            packet_cnt <= packet_cnt - 1'b1;
                            state <= (packet_cnt == PKT_W'(1)) ? OUT_STOP_CMD : OUT_DATA_CMD;
                        end
                    end
                    OUT_STOP_CMD: state <= OUT_IDLE;
                    default:      state <= OUT_IDLE;
                endcase
            end
        end
    end

endmodule

//--- sim.f
common/ft2232_pkg.sv
hdl/ft2232_flow_ctrl.sv
out_path/ft2232_out_sequencer.sv
in_path/ft2232_in_parser.sv
hdl/ft2232_host_model.sv
tests/ft2232_host_assertions.sv
tests/tb_ft2232_host_model.sv

//--- tests/ft2232_golden.mem
// Each word is one step: opcode byte above value byte
// 00 reset, 01 read byte, 02 write byte, 03 halt reason,
// 04 stopped with code, 05 expected byte, FF end
0000
// Outgoing stream: setup, config, two packets, stop
0101 01AE 0148
0100 0101 0102 0103 0104 0105 0106 0107
0148
0108 0109 010A 010B 010C 010D 010E 010F
01C0
// Stream config, then stream input bytes 0 to 7
0201 02AE
0248 0200 0201 0202 0203 0204 0205 0206 0207
0300 0508
// Stopped with code 2A
02C3 022A 0200 0200
042A
// Data mismatch
0000 0248 0205 0301
// Unknown command
0000 0280 0302
FF00

//--- tests/ft2232_host_assertions.sv
// ======================================================================
// Bound concurrent checks on the FT2232 RXF#/TXE# status levels
// ======================================================================

`timescale 1ns/1ps

module ft2232_host_assertions (
    input logic fifo_clk_o,
    input logic ft2232_reset_n_i,
    input logic out_done_i,
    input logic halted_i,
    input logic fifo_rxf_n_o,
    input logic fifo_txe_n_o
);

    // Set once the stream is done or the parser halted
    logic finished_q;

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            finished_q <= 1'b0;
        end else if (out_done_i || halted_i) begin
            finished_q <= 1'b1;
        end
    end

    txe_needs_halt: assert property (@(posedge fifo_clk_o) disable iff (!ft2232_reset_n_i)
        fifo_txe_n_o |-> halted_i)
        else $error("TXE# high while the parser is not halted");

    rxf_stays_high: assert property (@(posedge fifo_clk_o) disable iff (!ft2232_reset_n_i)
        finished_q |-> fifo_rxf_n_o)
        else $error("RXF# low after the stream finished or halted");

endmodule

bind ft2232_flow_ctrl ft2232_host_assertions ft2232_host_assertions_inst (
    .fifo_clk_o      (fifo_clk_o),
    .ft2232_reset_n_i(ft2232_reset_n_i),
    .out_done_i      (out_done_i),
    .halted_i        (halted_i),
    .fifo_rxf_n_o    (fifo_rxf_n_o),
    .fifo_txe_n_o    (fifo_txe_n_o)
);

//--- tests/tb_ft2232_host_model.sv
// ======================================================================
// Testbench for the FT2232 host model: clock, reset, golden-file steps,
// typed compare tasks and a watchdog
// ======================================================================

`timescale 1ns/1ps

module tb_ft2232_host_model;

    localparam int PACKET_COUNT     = 2;
    localparam int PACKET_PAYLOAD   = 8;
    localparam int OUT_EMPTY_CYCLES = 5;
    // Bytes read before the stall: setup, config, data header, half a payload
    localparam int STALL_AFTER      = 3 + PACKET_PAYLOAD / 2;
    localparam int GOLDEN_DEPTH     = 64;
    localparam int CYCLES_PER_STEP  = 40;
    localparam logic [15:0] LFSR_SEED = 16'd18282;

    // Golden step opcodes
    localparam logic [7:0] OP_RESET    = 8'h00;
    localparam logic [7:0] OP_READ     = 8'h01;
    localparam logic [7:0] OP_WRITE    = 8'h02;
    localparam logic [7:0] OP_HALT     = 8'h03;
    localparam logic [7:0] OP_STOPPED  = 8'h04;
    localparam logic [7:0] OP_EXPECTED = 8'h05;
    localparam logic [7:0] OP_END      = 8'hFF;

    logic                        osc_clk_i = 1'b0;
    logic                        ft2232_reset_n_i;
    logic                        fifo_oe_n_i;
    logic                        fifo_rd_n_i;
    logic                        fifo_wr_n_i;
    ft2232_pkg::ft_byte_t        fifo_data_i;
    logic                        fifo_clk_o;
    logic                        fifo_rxf_n_o;
    logic                        fifo_txe_n_o;
    ft2232_pkg::ft_byte_t        fifo_data_o;
    ft2232_pkg::ft_host_status_t status_o;

    logic [15:0] golden_mem [0:GOLDEN_DEPTH-1];
    logic [15:0] lfsr_state;
    int          n_steps;
    logic        steps_ready;
    int          read_cnt;
    int          stalls_seen;

    ft2232_host_model #(
        .PACKET_COUNT    (PACKET_COUNT),
        .PACKET_PAYLOAD  (PACKET_PAYLOAD),
        .OUT_EMPTY_CYCLES(OUT_EMPTY_CYCLES)
    ) ft2232_host_model_inst (
        .osc_clk_i       (osc_clk_i),
        .ft2232_reset_n_i(ft2232_reset_n_i),
        .fifo_oe_n_i     (fifo_oe_n_i),
        .fifo_rd_n_i     (fifo_rd_n_i),
        .fifo_wr_n_i     (fifo_wr_n_i),
        .fifo_data_i     (fifo_data_i),
        .fifo_clk_o      (fifo_clk_o),
        .fifo_rxf_n_o    (fifo_rxf_n_o),
        .fifo_txe_n_o    (fifo_txe_n_o),
        .fifo_data_o     (fifo_data_o),
        .status_o        (status_o)
    );

    // 4 ns oscillator
    always #2 osc_clk_i = ~osc_clk_i;

    // ==================================================================
    // Failure handling and compare tasks
    // ==================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_byte(input string name, input ft2232_pkg::ft_byte_t got,
                              input ft2232_pkg::ft_byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic verify_halt(input ft2232_pkg::ft_halt_e got,
                               input ft2232_pkg::ft_halt_e exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] status_o.halt: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic compare_stop(input logic got_stopped, input ft2232_pkg::ft_byte_t got_code,
                                input logic exp_stopped, input ft2232_pkg::ft_byte_t exp_code);
        if (got_stopped !== exp_stopped || got_code !== exp_code) begin
            abort_run($sformatf({"[ERROR] status_o.stopped/stop_code: got 0x%h/0x%h, ",
                                 "expected 0x%h/0x%h"},
                                got_stopped, got_code, exp_stopped, exp_code));
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // ==================================================================
    // Bus tasks, all start and end 1 ns after a clock edge
    // ==================================================================

    task automatic apply_reset();
        ft2232_reset_n_i = 1'b0;
        fifo_oe_n_i      = 1'b1;
        fifo_rd_n_i      = 1'b1;
        fifo_wr_n_i      = 1'b1;
        repeat (3) begin
            @(posedge osc_clk_i);
            #1;
            expect_level("fifo_clk_o", fifo_clk_o, 1'b0);
        end
        // Release while the oscillator is low to avoid a short clock pulse
        @(negedge osc_clk_i);
        #1;
        ft2232_reset_n_i = 1'b1;
        @(posedge fifo_clk_o);
        #1;
        expect_level("fifo_rxf_n_o", fifo_rxf_n_o, 1'b0);
        expect_level("fifo_txe_n_o", fifo_txe_n_o, 1'b0);
        verify_halt(status_o.halt, ft2232_pkg::HALT_NONE);
        compare_stop(status_o.stopped, status_o.stop_code, 1'b0, 8'h00);
        check_byte("status_o.expected", status_o.expected, 8'h00);
        read_cnt    = 0;
        stalls_seen = 0;
    endtask

    task automatic read_stream_byte(output ft2232_pkg::ft_byte_t got);
        logic done;
        int   high_cycles;
        done = 1'b0;
        lfsr_state = lfsr_next(lfsr_state);
        if (lfsr_state[0]) begin
            // Idle RD# for one cycle
            @(posedge fifo_clk_o);
            #1;
        end
        while (!done) begin
            while (fifo_rxf_n_o) begin
                @(posedge fifo_clk_o);
                #1;
            end
            fifo_oe_n_i = 1'b0;
            fifo_rd_n_i = 1'b0;
            @(posedge fifo_clk_o);
            #1;
            fifo_rd_n_i = 1'b1;
            fifo_oe_n_i = 1'b1;
            if (fifo_rxf_n_o) begin
                // Empty FIFO window instead of a byte
                high_cycles = 0;
                while (fifo_rxf_n_o) begin
                    @(posedge fifo_clk_o);
                    #1;
                    high_cycles++;
                end
                if (stalls_seen != 0) begin
                    abort_run("RXF# empty window opened more than once");
                end
                if (read_cnt != STALL_AFTER) begin
                    abort_run($sformatf("RXF# empty window came after %0d bytes, not %0d",
                                        read_cnt, STALL_AFTER));
                end
                if (high_cycles != OUT_EMPTY_CYCLES) begin
                    abort_run($sformatf("RXF# empty window lasted %0d cycles, not %0d",
                                        high_cycles, OUT_EMPTY_CYCLES));
                end
                stalls_seen++;
            end else begin
                got  = fifo_data_o;
                done = 1'b1;
            end
        end
        read_cnt++;
        if (OUT_EMPTY_CYCLES > 0 && read_cnt == STALL_AFTER + 1 && stalls_seen != 1) begin
            abort_run("RXF# never opened the empty window in the first packet");
        end
    endtask

    task automatic write_host_byte(input ft2232_pkg::ft_byte_t value);
        while (fifo_txe_n_o) begin
            @(posedge fifo_clk_o);
            #1;
        end
        fifo_oe_n_i = 1'b1;
        fifo_data_i = value;
        fifo_wr_n_i = 1'b0;
        @(posedge fifo_clk_o);
        #1;
        fifo_wr_n_i = 1'b1;
    endtask

    // ==================================================================
    // Golden step sequencer
    // ==================================================================

    initial begin
        logic [7:0]           op;
        logic [7:0]           value;
        ft2232_pkg::ft_byte_t got;
        ft2232_pkg::ft_halt_e exp_halt;
        int                   step;
        ft2232_reset_n_i = 1'b0;
        fifo_oe_n_i      = 1'b1;
        fifo_rd_n_i      = 1'b1;
        fifo_wr_n_i      = 1'b1;
        fifo_data_i      = 8'h00;
        lfsr_state       = LFSR_SEED;
        read_cnt         = 0;
        stalls_seen      = 0;
        steps_ready      = 1'b0;
        n_steps          = 0;
        $readmemh("tests/ft2232_golden.mem", golden_mem);
        for (step = 0; step < GOLDEN_DEPTH && n_steps == 0; step++) begin
            if (golden_mem[step][15:8] == OP_END) begin
                n_steps = step + 1;
            end
        end
        if (n_steps == 0) begin
            abort_run("Golden file holds no end step");
        end
        steps_ready = 1'b1;
        // The last step only marks the end
        for (step = 0; step < n_steps - 1; step++) begin
            op    = golden_mem[step][15:8];
            value = golden_mem[step][7:0];
            case (op)
                OP_RESET: apply_reset();
                OP_READ: begin
                    read_stream_byte(got);
                    check_byte("fifo_data_o", got, value);
                end
                OP_WRITE: write_host_byte(value);
                OP_HALT: begin
                    exp_halt = ft2232_pkg::ft_halt_e'(value[1:0]);
                    verify_halt(status_o.halt, exp_halt);
                    // TXE# follows the halt one cycle later
                    @(posedge fifo_clk_o);
                    #1;
                    expect_level("fifo_txe_n_o", fifo_txe_n_o,
                                 exp_halt != ft2232_pkg::HALT_NONE);
                end
                OP_STOPPED: begin
                    compare_stop(status_o.stopped, status_o.stop_code, 1'b1, value);
                    expect_level("fifo_rxf_n_o", fifo_rxf_n_o, 1'b1);
                end
                OP_EXPECTED: check_byte("status_o.expected", status_o.expected, value);
                default: abort_run($sformatf("Unknown golden opcode 0x%h at step %0d", op, step));
            endcase
        end
        $display("TB PASSED");
        $finish;
    end

    // Watchdog, budget scales with the number of golden steps
    initial begin
        wait (steps_ready);
        repeat (n_steps * CYCLES_PER_STEP) @(posedge osc_clk_i);
        abort_run("Watchdog expired before the golden steps finished");
    end

endmodule
